//--- common/icache_consts.svh
// Instruction cache geometry constants
`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

// Address and instruction widths
`define IC_PLEN 32
`define IC_ILEN 32

// Line layout, 4 instructions make a 128-bit line
`define IC_LINE_WORDS 4
// Instructions returned per fetch group
`define IC_FETCH_NUM 2

// Associativity and set count, 16 sets
`define IC_NUM_WAYS 2
`define IC_INDEX_W 4

// Byte offset inside a line
`define IC_OFFSET_W 4
// Tag is what is left of the address above index and offset
`define IC_TAG_W 24

// Replacement LFSR width
`define IC_LFSR_W 4

`endif

//--- common/icache_pkg.sv
// Instruction cache vector types and controller state encoding
`include "icache_consts.svh"

package icache_pkg;

  // Addresses and address fields
  typedef logic [`IC_PLEN-1:0] paddr_t;
  typedef logic [`IC_TAG_W-1:0] tag_t;
  typedef logic [`IC_INDEX_W-1:0] index_t;
  // Instruction slot inside a line
  typedef logic [$clog2(`IC_LINE_WORDS)-1:0] slot_t;
  typedef logic [$clog2(`IC_NUM_WAYS)-1:0] way_t;

  // Payload
  typedef logic [`IC_ILEN-1:0] instr_t;
  typedef logic [`IC_LINE_WORDS*`IC_ILEN-1:0] line_t;
  typedef logic [`IC_FETCH_NUM*`IC_ILEN-1:0] fetch_t;

  // Controller FSM
  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    MISS_REQ,
    MISS_WAIT,
    RECOVER
  } ic_state_e;

endpackage

//--- common/ic_lookup_if.sv
// Interface for an accepted fetch request's decoded fields
interface ic_lookup_if;

  // One-cycle pulse in the accept cycle
  logic accept;
  // Fields held from accept until the next accept
  icache_pkg::tag_t tag;
  icache_pkg::index_t index;
  icache_pkg::slot_t slot;
  // Flush request, straight from the fetch unit
  logic flush;

  modport dec (output accept, output tag, output index, output slot, output flush);

  // Controller compares tags and builds the miss address
  modport ctrl (input accept, input tag, input index, input flush);

  modport resp (input accept, input slot, input flush);

endinterface

//--- common/ic_fill_if.sv
// Interface for the refill write into the cache arrays
interface ic_fill_if;

  // Write strobe, one cycle per refill
  logic we;
  icache_pkg::way_t way;
  icache_pkg::index_t index;
  icache_pkg::tag_t tag;
  icache_pkg::line_t line;

  // Controller owns the write
  modport ctrl (output we, output way, output index, output tag, output line);

  modport arr (input we, input way, input index, input tag, input line);

endinterface

//--- logic/ic_req_decode.sv
// Fetch request decoder with accept pulse, PC split and early array read index
`include "icache_consts.svh"

module ic_req_decode (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                req_valid_i,
  input  icache_pkg::paddr_t  req_pc_i,
  input  logic                flush_i,
  input  logic                ready_i,
  output icache_pkg::index_t  rd_index_o,
  ic_lookup_if.dec            lk
);

  // Byte offset bits below the instruction slot
  localparam int unsigned INSTR_OFF_W = $clog2(`IC_ILEN / 8);

  logic               accept;
  icache_pkg::tag_t   pc_tag;
  icache_pkg::index_t pc_index;
  icache_pkg::slot_t  pc_slot;
  icache_pkg::tag_t   tag_q;
  icache_pkg::index_t index_q;
  icache_pkg::slot_t  slot_q;

  // A flush always wins over a new request
  assign accept = req_valid_i && ready_i && !flush_i;

  // PC layout is tag | index | slot | byte
  assign pc_tag   = req_pc_i[`IC_OFFSET_W+`IC_INDEX_W +: `IC_TAG_W];
  assign pc_index = req_pc_i[`IC_OFFSET_W +: `IC_INDEX_W];
  assign pc_slot  = req_pc_i[INSTR_OFF_W +: $bits(icache_pkg::slot_t)];

  // Read the arrays with the new index in the accept cycle so data is out in LOOKUP
  assign rd_index_o = accept ? pc_index : index_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      index_q <= '0;
    end else if (accept) begin
      index_q <= pc_index;
    end
  end

  // Tag and slot of the accepted request
  always_ff @(posedge clk_i) begin
    if (accept) begin
      tag_q  <= pc_tag;
      slot_q <= pc_slot;
    end
  end

  assign lk.accept = accept;
  assign lk.tag    = tag_q;
  assign lk.index  = index_q;
  assign lk.slot   = slot_q;
  assign lk.flush  = flush_i;

endmodule

//--- cache_array/ic_arrays.sv
// Cache tag, valid and data arrays with one registered read port and one write port
`include "icache_consts.svh"

module ic_arrays (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  icache_pkg::index_t                     rd_index_i,
  output icache_pkg::tag_t  [`IC_NUM_WAYS-1:0]   tags_o,
  output logic              [`IC_NUM_WAYS-1:0]   valids_o,
  output icache_pkg::line_t [`IC_NUM_WAYS-1:0]   lines_o,
  ic_fill_if.arr                                 fill
);

  localparam int unsigned NUM_SETS = 1 << `IC_INDEX_W;

  // Storage, one entry per way and set
  icache_pkg::tag_t  tag_mem  [`IC_NUM_WAYS][NUM_SETS];
  icache_pkg::line_t data_mem [`IC_NUM_WAYS][NUM_SETS];
  logic [`IC_NUM_WAYS-1:0][NUM_SETS-1:0] valid_q;

  // ------------------------------------------------------------------
  // Tag and data memories
  // ------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (fill.we) begin
      tag_mem[fill.way][fill.index]  <= fill.tag;
      data_mem[fill.way][fill.index] <= fill.line;
    end
    // Read sees the old entry when it hits the set being written
    for (int w = 0; w < `IC_NUM_WAYS; w++) begin
      tags_o[w]  <= tag_mem[w][rd_index_i];
      lines_o[w] <= data_mem[w][rd_index_i];
    end
  end

  // ------------------------------------------------------------------
  // Valid bits
  // ------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q  <= '0;
      valids_o <= '0;
    end else begin
      // Refill sets the bit, nothing clears it short of reset
      if (fill.we) begin
        valid_q[fill.way][fill.index] <= 1'b1;
      end
      for (int w = 0; w < `IC_NUM_WAYS; w++) begin
        valids_o[w] <= valid_q[w][rd_index_i];
      end
    end
  end

  // Refill target comes from the controller's saved miss context
  fill_target_known_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    fill.we |-> !$isunknown({fill.way, fill.index})
  );

endmodule

//--- logic/ic_ctrl.sv
// Cache controller with FSM, hit compare, LFSR victim choice, miss port and refill write
`include "icache_consts.svh"

module ic_ctrl (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  ic_lookup_if.ctrl                             lk,
  input  icache_pkg::tag_t  [`IC_NUM_WAYS-1:0]  tags_i,
  input  logic              [`IC_NUM_WAYS-1:0]  valids_i,
  input  icache_pkg::line_t [`IC_NUM_WAYS-1:0]  lines_i,
  output logic                                  ready_o,
  output logic                                  hit_o,
  output icache_pkg::line_t                     hit_line_o,
  output logic                                  miss_req_valid_o,
  input  logic                                  miss_req_ready_i,
  output icache_pkg::paddr_t                    miss_req_paddr_o,
  output icache_pkg::way_t                      miss_req_way_o,
  input  logic                                  refill_valid_i,
  output logic                                  refill_ready_o,
  input  icache_pkg::line_t                     refill_data_i,
  ic_fill_if.ctrl                               fill
);

  icache_pkg::ic_state_e state_q, state_d;
  logic                    killed_q;
  logic [`IC_LFSR_W-1:0]   lfsr_q;
  logic [`IC_NUM_WAYS-1:0] hit_vec;
  logic                    hit_any;
  icache_pkg::way_t        hit_idx;
  icache_pkg::way_t        inv_idx;
  icache_pkg::way_t        victim;
  // Miss context held from LOOKUP until the refill lands
  icache_pkg::tag_t        miss_tag_q;
  icache_pkg::index_t      miss_index_q;
  icache_pkg::way_t        miss_way_q;

  // ------------------------------------------------------------------
  // Hit compare and victim choice
  // ------------------------------------------------------------------
  for (genvar w = 0; w < `IC_NUM_WAYS; w++) begin : gen_hit
    assign hit_vec[w] = valids_i[w] && (tags_i[w] == lk.tag);
  end
  assign hit_any = |hit_vec;

  // Lowest matching way and lowest invalid way
  always_comb begin
    hit_idx = '0;
    inv_idx = '0;
    for (int w = `IC_NUM_WAYS - 1; w >= 0; w--) begin
      if (hit_vec[w]) hit_idx = icache_pkg::way_t'(w);
      if (!valids_i[w]) inv_idx = icache_pkg::way_t'(w);
    end
  end

  // Full set falls back to the LFSR
  assign victim     = (&valids_i) ? lfsr_q[$bits(icache_pkg::way_t)-1:0] : inv_idx;
  assign hit_line_o = lines_i[hit_idx];
  // No response for a killed request or one flushed right now
  assign hit_o = (state_q == icache_pkg::LOOKUP) && hit_any && !killed_q && !lk.flush;

  // ------------------------------------------------------------------
  // FSM
  // ------------------------------------------------------------------
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      icache_pkg::IDLE:      if (lk.accept) state_d = icache_pkg::LOOKUP;
      icache_pkg::LOOKUP:    state_d = hit_any ? icache_pkg::IDLE : icache_pkg::MISS_REQ;
      icache_pkg::MISS_REQ:  if (miss_req_ready_i) state_d = icache_pkg::MISS_WAIT;
      icache_pkg::MISS_WAIT: if (refill_valid_i) state_d = icache_pkg::RECOVER;
      // Quiet cycle so the array read picks up the new line
      icache_pkg::RECOVER:   state_d = icache_pkg::LOOKUP;
      default:               state_d = icache_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= icache_pkg::IDLE;
      killed_q <= 1'b0;
      lfsr_q   <= `IC_LFSR_W'(1);
    end else begin
      state_q <= state_d;
      // Free-running LFSR with taps for x^4 + x^3 + 1
      lfsr_q  <= {lfsr_q[`IC_LFSR_W-2:0], lfsr_q[`IC_LFSR_W-1] ^ lfsr_q[`IC_LFSR_W-2]};
      // Flush in flight lets the refill finish but drops the answer
      if (lk.accept) begin
        killed_q <= 1'b0;
      end else if (lk.flush && state_q != icache_pkg::IDLE) begin
        killed_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == icache_pkg::LOOKUP && !hit_any) begin
      miss_tag_q   <= lk.tag;
      miss_index_q <= lk.index;
      miss_way_q   <= victim;
    end
  end

  // ------------------------------------------------------------------
  // Miss and refill ports
  // ------------------------------------------------------------------
  assign ready_o          = (state_q == icache_pkg::IDLE);
  assign miss_req_valid_o = (state_q == icache_pkg::MISS_REQ);
  // Line-aligned address
  assign miss_req_paddr_o = {miss_tag_q, miss_index_q, {`IC_OFFSET_W{1'b0}}};
  assign miss_req_way_o   = miss_way_q;
  assign refill_ready_o   = (state_q == icache_pkg::MISS_WAIT);

  assign fill.we    = refill_ready_o && refill_valid_i;
  assign fill.way   = miss_way_q;
  assign fill.index = miss_index_q;
  assign fill.tag   = miss_tag_q;
  assign fill.line  = refill_data_i;

  miss_req_hold_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    miss_req_valid_o && !miss_req_ready_i |=>
      miss_req_valid_o && $stable(miss_req_paddr_o) && $stable(miss_req_way_o)
  );

  // Refills never leave two ways of a set holding the same tag
  single_hit_way_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (state_q == icache_pkg::LOOKUP) |-> $onehot0(hit_vec)
  );

endmodule

//--- logic/ic_fetch_resp.sv
// Fetch response stage with fetch group select from the hit line and response register
`include "icache_consts.svh"

module ic_fetch_resp (
  input  logic                clk_i,
  input  logic                rst_ni,
  ic_lookup_if.resp           lk,
  input  logic                hit_i,
  input  icache_pkg::line_t   hit_line_i,
  output logic                rsp_valid_o,
  output icache_pkg::fetch_t  rsp_instrs_o
);

  icache_pkg::fetch_t group;

  // Consecutive words from the start slot within one line
  always_comb begin
    icache_pkg::slot_t word_idx;
    group = '0;
    for (int i = 0; i < `IC_FETCH_NUM; i++) begin
      word_idx = icache_pkg::slot_t'(lk.slot + i);
      group[i*`IC_ILEN +: `IC_ILEN] = hit_line_i[word_idx*`IC_ILEN +: `IC_ILEN];
    end
  end

  // ------------------------------------------------------------------
  // Response register
  // ------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_valid_o <= 1'b0;
    end else if (lk.flush || lk.accept) begin
      // Held answer is stale once a new request or flush arrives
      rsp_valid_o <= 1'b0;
    end else if (hit_i) begin
      rsp_valid_o <= 1'b1;
    end
  end

  // Fetch group captured on the hit
  always_ff @(posedge clk_i) begin
    if (hit_i) begin
      rsp_instrs_o <= group;
    end
  end

endmodule

//--- logic/icache_top.sv
// Instruction cache top level: decoder, arrays, controller and response stage
`include "icache_consts.svh"

module icache_top (
  input  logic                clk_i,
  input  logic                rst_ni,
  // Fetch unit side
  input  logic                req_valid_i,
  output logic                req_ready_o,
  input  icache_pkg::paddr_t  req_pc_i,
  input  logic                flush_i,
  output logic                rsp_valid_o,
  output icache_pkg::fetch_t  rsp_instrs_o,
  // Memory side
  output logic                miss_req_valid_o,
  input  logic                miss_req_ready_i,
  output icache_pkg::paddr_t  miss_req_paddr_o,
  output icache_pkg::way_t    miss_req_way_o,
  input  logic                refill_valid_i,
  output logic                refill_ready_o,
  input  icache_pkg::line_t   refill_data_i
);

  ic_lookup_if lk_if ();
  ic_fill_if   fill_if ();

  icache_pkg::index_t                    rd_index;
  icache_pkg::tag_t  [`IC_NUM_WAYS-1:0]  tags;
  logic              [`IC_NUM_WAYS-1:0]  valids;
  icache_pkg::line_t [`IC_NUM_WAYS-1:0]  lines;
  logic                                  hit;
  icache_pkg::line_t                     hit_line;

  ic_req_decode req_decode_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (req_valid_i),
    .req_pc_i    (req_pc_i),
    .flush_i     (flush_i),
    .ready_i     (req_ready_o),
    .rd_index_o  (rd_index),
    .lk          (lk_if.dec)
  );

  ic_arrays arrays_inst (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .rd_index_i (rd_index),
    .tags_o     (tags),
    .valids_o   (valids),
    .lines_o    (lines),
    .fill       (fill_if.arr)
  );

  ic_ctrl ctrl_inst (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .lk               (lk_if.ctrl),
    .tags_i           (tags),
    .valids_i         (valids),
    .lines_i          (lines),
    .ready_o          (req_ready_o),
    .hit_o            (hit),
    .hit_line_o       (hit_line),
    .miss_req_valid_o (miss_req_valid_o),
    .miss_req_ready_i (miss_req_ready_i),
    .miss_req_paddr_o (miss_req_paddr_o),
    .miss_req_way_o   (miss_req_way_o),
    .refill_valid_i   (refill_valid_i),
    .refill_ready_o   (refill_ready_o),
    .refill_data_i    (refill_data_i),
    .fill             (fill_if.ctrl)
  );

  ic_fetch_resp fetch_resp_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .lk           (lk_if.resp),
    .hit_i        (hit),
    .hit_line_i   (hit_line),
    .rsp_valid_o  (rsp_valid_o),
    .rsp_instrs_o (rsp_instrs_o)
  );

endmodule

//--- dv/tb_clk_gen.sv
// Testbench clock and active-low reset generator
module tb_clk_gen #(
  parameter int unsigned PERIOD     = 8,
  parameter int unsigned RST_CYCLES = 5
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  // Reset released on a falling edge, away from the sampling edge
  initial begin
    rst_no = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

//--- dv/icache_tb.sv
// Instruction cache testbench with memory model, reference data, directed and random fetch checks
`include "icache_consts.svh"

module icache_tb;

  localparam int unsigned TIMEOUT  = 200;
  localparam int unsigned NUM_SETS = 1 << `IC_INDEX_W;
  // Scramble so line data never equals its own address
  localparam logic [31:0] DATA_KEY = 32'h5a5a_c3c3;

  logic               clk;
  logic               rst_n;
  logic               req_valid = 1'b0;
  logic               req_ready;
  icache_pkg::paddr_t req_pc = '0;
  logic               flush = 1'b0;
  logic               rsp_valid;
  icache_pkg::fetch_t rsp_instrs;
  logic               miss_valid;
  logic               miss_ready = 1'b0;
  icache_pkg::paddr_t miss_paddr;
  icache_pkg::way_t   miss_way;
  logic               refill_valid = 1'b0;
  logic               refill_ready;
  icache_pkg::line_t  refill_data = '0;

  // Memory model state
  int unsigned        mem_phase = 0;
  int unsigned        delay_cnt = 0;
  int unsigned        miss_count = 0;
  logic               bp_en = 1'b0;
  logic               held = 1'b0;
  icache_pkg::paddr_t held_addr;
  icache_pkg::way_t   held_way;
  icache_pkg::paddr_t last_miss_addr;
  icache_pkg::way_t   last_miss_way;

  // Cache contents as the testbench expects them
  icache_pkg::tag_t   exp_tag   [`IC_NUM_WAYS][NUM_SETS];
  logic               exp_valid [`IC_NUM_WAYS][NUM_SETS];
  // Tags used by the random stream
  icache_pkg::tag_t   tag_pool  [4] = '{24'h000123, 24'h000456, 24'h0ab789, 24'hfff000};

  tb_clk_gen #(.PERIOD(8), .RST_CYCLES(5)) clk_gen_inst (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  icache_top icache_top_inst (
    .clk_i            (clk),
    .rst_ni           (rst_n),
    .req_valid_i      (req_valid),
    .req_ready_o      (req_ready),
    .req_pc_i         (req_pc),
    .flush_i          (flush),
    .rsp_valid_o      (rsp_valid),
    .rsp_instrs_o     (rsp_instrs),
    .miss_req_valid_o (miss_valid),
    .miss_req_ready_i (miss_ready),
    .miss_req_paddr_o (miss_paddr),
    .miss_req_way_o   (miss_way),
    .refill_valid_i   (refill_valid),
    .refill_ready_o   (refill_ready),
    .refill_data_i    (refill_data)
  );

  // ------------------------------------------------------------------
  // Reference data and expected cache state
  // ------------------------------------------------------------------
  function automatic icache_pkg::paddr_t line_base(icache_pkg::paddr_t pc);
    return {pc[`IC_PLEN-1:`IC_OFFSET_W], {`IC_OFFSET_W{1'b0}}};
  endfunction

  function automatic icache_pkg::index_t set_of(icache_pkg::paddr_t pc);
    return pc[`IC_OFFSET_W +: `IC_INDEX_W];
  endfunction

  function automatic icache_pkg::tag_t tag_of(icache_pkg::paddr_t pc);
    return pc[`IC_PLEN-1 -: `IC_TAG_W];
  endfunction

  // Word k of a line is the line address plus 4k scrambled by the key
  function automatic icache_pkg::instr_t word_at(icache_pkg::paddr_t base, int k);
    return (base + 32'(4 * k)) ^ DATA_KEY;
  endfunction

  function automatic icache_pkg::line_t line_data(icache_pkg::paddr_t base);
    icache_pkg::line_t line;
    for (int k = 0; k < `IC_LINE_WORDS; k++) begin
      line[k*`IC_ILEN +: `IC_ILEN] = word_at(base, k);
    end
    return line;
  endfunction

  // Group starts at the PC's word and stays inside its line
  function automatic icache_pkg::fetch_t expected_group(icache_pkg::paddr_t pc);
    icache_pkg::fetch_t grp;
    int first;
    first = int'(pc[`IC_OFFSET_W-1:2]);
    for (int i = 0; i < `IC_FETCH_NUM; i++) begin
      grp[i*`IC_ILEN +: `IC_ILEN] = word_at(line_base(pc), first + i);
    end
    return grp;
  endfunction

  // Way holding the PC's line or -1 on a miss
  function automatic int lookup_way(icache_pkg::paddr_t pc);
    int found;
    found = -1;
    for (int w = 0; w < `IC_NUM_WAYS; w++) begin
      if (exp_valid[w][set_of(pc)] && exp_tag[w][set_of(pc)] == tag_of(pc)) begin
        found = w;
      end
    end
    return found;
  endfunction

  // Lowest invalid way or -1 when the set is full and the LFSR decides
  function automatic int pick_victim(icache_pkg::paddr_t pc);
    int v;
    v = -1;
    for (int w = `IC_NUM_WAYS - 1; w >= 0; w--) begin
      if (!exp_valid[w][set_of(pc)]) begin
        v = w;
      end
    end
    return v;
  endfunction

  function automatic void record_fill(icache_pkg::paddr_t pc, icache_pkg::way_t way);
    exp_tag[way][set_of(pc)]   = tag_of(pc);
    exp_valid[way][set_of(pc)] = 1'b1;
  endfunction

  // ------------------------------------------------------------------
  // Checks and waits
  // ------------------------------------------------------------------
  task automatic fail_stop(string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_eq(string what, logic [127:0] got, logic [127:0] exp);
    if (got !== exp) begin
      fail_stop($sformatf("[FAIL] %0t: %s got %0h expected %0h", $time, what, got, exp));
    end
  endtask

  task automatic wait_ready();
    int unsigned n;
    n = 0;
    while (req_ready !== 1'b1) begin
      if (n >= TIMEOUT) fail_stop("Timeout: the cache never became ready for a request");
      @(negedge clk);
      n++;
    end
  endtask

  // One fetch with data, latency and miss traffic checked against the model
  task automatic do_fetch(icache_pkg::paddr_t pc, output logic was_hit);
    int          exp_way;
    int          victim;
    int unsigned misses_before;
    int unsigned cycles;
    exp_way = lookup_way(pc);
    victim  = pick_victim(pc);
    wait_ready();
    misses_before = miss_count;
    req_valid = 1'b1;
    req_pc    = pc;
    @(negedge clk);
    req_valid = 1'b0;
    cycles    = 1;
    while (rsp_valid !== 1'b1) begin
      if (cycles >= TIMEOUT) fail_stop($sformatf("Timeout: no response for PC %h", pc));
      @(negedge clk);
      cycles++;
    end
    check_eq("fetch group", 128'(rsp_instrs), 128'(expected_group(pc)));
    was_hit = (miss_count == misses_before);
    check_eq("hit as predicted", 128'(was_hit), 128'(exp_way >= 0));
    if (exp_way >= 0) begin
      check_eq("hit latency", 128'(cycles), 128'(2));
    end else begin
      check_eq("one miss request", 128'(miss_count), 128'(misses_before + 1));
      check_eq("miss address", 128'(last_miss_addr), 128'(line_base(pc)));
      // A full set leaves the choice to the LFSR and the issued way is recorded
      if (victim >= 0) check_eq("victim way", 128'(last_miss_way), 128'(victim));
      record_fill(pc, last_miss_way);
    end
  endtask

  // ------------------------------------------------------------------
  // Memory model stepping once per falling edge
  // ------------------------------------------------------------------
  always @(negedge clk) begin
    if (rst_n === 1'b1) begin
      case (mem_phase)
        0: begin
          // Stalled request must stay put
          if (held) begin
            check_eq("miss valid held", 128'(miss_valid), 128'(1));
            check_eq("miss address held", 128'(miss_paddr), 128'(held_addr));
            check_eq("miss way held", 128'(miss_way), 128'(held_way));
          end
          if (miss_valid === 1'b1) begin
            // Back-pressure always stalls the first cycle
            if (bp_en && (!held || ($urandom % 3) != 0)) begin
              held      = 1'b1;
              held_addr = miss_paddr;
              held_way  = miss_way;
            end else begin
              miss_ready <= 1'b1;
              held           = 1'b0;
              last_miss_addr = miss_paddr;
              last_miss_way  = miss_way;
              miss_count++;
              delay_cnt = $urandom % 4;
              mem_phase = 1;
            end
          end
        end
        1: begin
          miss_ready <= 1'b0;
          if (delay_cnt == 0) begin
            check_eq("refill ready while waiting", 128'(refill_ready), 128'(1));
            refill_valid <= 1'b1;
            refill_data  <= line_data(last_miss_addr);
            mem_phase = 2;
          end else begin
            delay_cnt--;
          end
        end
        default: begin
          refill_valid <= 1'b0;
          mem_phase = 0;
        end
      endcase
    end
  end

  // ------------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------------
  initial begin
    logic               hit;
    logic [1:0]         sel;
    int unsigned        n;
    int unsigned        misses;
    icache_pkg::paddr_t pc_a;
    icache_pkg::paddr_t pc_b;
    icache_pkg::paddr_t pc_c;
    icache_pkg::paddr_t pc;
    icache_pkg::paddr_t kept;
    icache_pkg::paddr_t gone;
    void'($urandom(32'hafad));
    for (int w = 0; w < `IC_NUM_WAYS; w++) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        exp_valid[w][s] = 1'b0;
      end
    end
    n = 0;
    while (rst_n !== 1'b1) begin
      if (n >= TIMEOUT) fail_stop("Timeout: reset was never released");
      @(negedge clk);
      n++;
    end
    @(negedge clk);
    check_eq("ready after reset", 128'(req_ready), 128'(1));
    check_eq("no response after reset", 128'(rsp_valid), 128'(0));
    check_eq("no miss after reset", 128'(miss_valid), 128'(0));
    check_eq("no refill window after reset", 128'(refill_ready), 128'(0));

    // Cold miss then hits on both groups of the line
    pc_a = {24'h000123, 4'h3, 4'h0};
    pc_b = {24'h000456, 4'h3, 4'h0};
    pc_c = {24'h000789, 4'h3, 4'h0};
    do_fetch(pc_a, hit);
    check_eq("cold miss", 128'(hit), 128'(0));
    check_eq("cold miss way", 128'(last_miss_way), 128'(0));
    do_fetch(pc_a, hit);
    check_eq("repeat hit", 128'(hit), 128'(1));
    do_fetch(pc_a + 32'd8, hit);
    check_eq("second group hit", 128'(hit), 128'(1));

    // Second tag takes way 1 and a third tag evicts by LFSR
    do_fetch(pc_b, hit);
    check_eq("second tag way", 128'(last_miss_way), 128'(1));
    do_fetch(pc_c, hit);
    check_eq("third tag miss", 128'(hit), 128'(0));
    kept = (last_miss_way == 1'b0) ? pc_b : pc_a;
    gone = (last_miss_way == 1'b0) ? pc_a : pc_b;
    do_fetch(kept + 32'd8, hit);
    check_eq("surviving tag hit", 128'(hit), 128'(1));
    do_fetch(gone, hit);
    check_eq("evicted tag miss", 128'(hit), 128'(0));

    // Misses under memory back-pressure
    bp_en = 1'b1;
    for (int i = 0; i < 4; i++) begin
      do_fetch({24'h000a00 + 24'(i), 4'h7, 4'h8}, hit);
      check_eq("back-pressure miss", 128'(hit), 128'(0));
    end
    bp_en = 1'b0;

    // Flush kills a pending miss whose refill still lands
    pc = {24'h000f00, 4'h9, 4'h0};
    wait_ready();
    misses    = miss_count;
    req_valid = 1'b1;
    req_pc    = pc;
    @(negedge clk);
    req_valid = 1'b0;
    n = 0;
    while (miss_valid !== 1'b1) begin
      if (n >= TIMEOUT) fail_stop("Timeout: no miss request for the flushed fetch");
      @(negedge clk);
      n++;
    end
    flush = 1'b1;
    @(negedge clk);
    flush = 1'b0;
    n = 0;
    while (req_ready !== 1'b1) begin
      check_eq("no response for killed fetch", 128'(rsp_valid), 128'(0));
      if (n >= TIMEOUT) fail_stop("Timeout: cache stuck after the flush");
      @(negedge clk);
      n++;
    end
    repeat (4) begin
      check_eq("no late response for killed fetch", 128'(rsp_valid), 128'(0));
      @(negedge clk);
    end
    check_eq("killed fetch missed once", 128'(miss_count), 128'(misses + 1));
    record_fill(pc, last_miss_way);
    do_fetch(pc + 32'd8, hit);
    check_eq("refilled line after flush", 128'(hit), 128'(1));

    // Random aligned PCs over a few tags and sets
    for (int i = 0; i < 80; i++) begin
      sel = 2'($urandom % 4);
      pc  = {tag_pool[sel], 4'($urandom % 4), 1'($urandom % 2), 3'b000};
      do_fetch(pc, hit);
    end

    $display("STATUS: PASS");
    $finish;
  end

endmodule

//--- vlog.f
+incdir+common
common/icache_pkg.sv
common/ic_lookup_if.sv
common/ic_fill_if.sv
logic/ic_req_decode.sv
cache_array/ic_arrays.sv
logic/ic_ctrl.sv
logic/ic_fetch_resp.sv
logic/icache_top.sv
dv/tb_clk_gen.sv
dv/icache_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the instruction cache testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -f sim.log
verilator --binary --timing --assert --top-module icache_tb -f vlog.f -o icache_sim

# Exit status of the simulator is not used, the log decides
./obj_dir/icache_sim | tee sim.log

if grep -q "STATUS: PASS" sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed"
  exit 1
fi
